// ==== common/muldiv_pkg.sv ====
package muldiv_pkg;

  // Data and tag widths.
  localparam int XLEN_W = 32;
  localparam int TAG_W  = 4;

  // M-extension opcodes, encoded as funct3.
  typedef enum logic [2:0] {
    OP_MUL    = 3'b000,
    OP_MULH   = 3'b001,
    OP_MULHSU = 3'b010,
    OP_MULHU  = 3'b011,
    OP_DIV    = 3'b100,
    OP_DIVU   = 3'b101,
    OP_REM    = 3'b110,
    OP_REMU   = 3'b111
  } muldiv_op_t;

  // Issue request from the core.
  typedef struct packed {
    logic [2:0]        funct3;
    logic [XLEN_W-1:0] rs1;
    logic [XLEN_W-1:0] rs2;
    logic [TAG_W-1:0]  tag;
  } muldiv_req_t;

  // Decoded request with operands extended by their signedness.
  typedef struct packed {
    muldiv_op_t        op;
    logic [XLEN_W:0]   rs1;
    logic [XLEN_W:0]   rs2;
    logic [TAG_W-1:0]  tag;
  } muldiv_disp_t;

  // Tagged result.
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [XLEN_W-1:0] data;
  } muldiv_res_t;

endpackage

// ==== source/muldiv_decode.sv ====
`timescale 1ns/100ps

module muldiv_decode (
  input  logic                     i_req_valid,
  input  muldiv_pkg::muldiv_req_t  i_req,
  input  logic                     i_div_idle,
  output logic                     o_req_ready,
  output logic                     o_mul_valid,
  output logic                     o_div_valid,
  output muldiv_pkg::muldiv_disp_t o_disp
);

  muldiv_pkg::muldiv_op_t w_op;
  logic                   w_is_div;
  logic                   w_rs1_signed;
  logic                   w_rs2_signed;

  assign w_op = muldiv_pkg::muldiv_op_t'(i_req.funct3);

  // Divide class is the upper half of funct3.
  assign w_is_div = w_op inside {muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU,
                                 muldiv_pkg::OP_REM, muldiv_pkg::OP_REMU};

  assign w_rs1_signed = w_op inside {muldiv_pkg::OP_MUL, muldiv_pkg::OP_MULH,
                                     muldiv_pkg::OP_MULHSU, muldiv_pkg::OP_DIV,
                                     muldiv_pkg::OP_REM};

  assign w_rs2_signed = w_op inside {muldiv_pkg::OP_MUL, muldiv_pkg::OP_MULH,
                                     muldiv_pkg::OP_DIV, muldiv_pkg::OP_REM};

  // Multiplies always go; divides wait for an idle divider.
  assign o_req_ready = !w_is_div || i_div_idle;

  assign o_mul_valid = i_req_valid && !w_is_div;
  assign o_div_valid = i_req_valid && w_is_div && i_div_idle;

  // One extra bit carries the operand sign into the execute units.
  assign o_disp.op  = w_op;
  assign o_disp.rs1 = {w_rs1_signed && i_req.rs1[muldiv_pkg::XLEN_W-1], i_req.rs1};
  assign o_disp.rs2 = {w_rs2_signed && i_req.rs2[muldiv_pkg::XLEN_W-1], i_req.rs2};
  assign o_disp.tag = i_req.tag;

endmodule

// ==== muldiv/muldiv_mul_pipe.sv ====
`timescale 1ns/100ps

module muldiv_mul_pipe #(
  parameter int MUL_UNROLL = 8
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_valid,
  input  muldiv_pkg::muldiv_disp_t i_disp,
  output logic                     o_valid,
  output muldiv_pkg::muldiv_res_t  o_res
);

  localparam int XLEN_W   = muldiv_pkg::XLEN_W;
  localparam int MUL_STEP = (XLEN_W + MUL_UNROLL - 1) / MUL_UNROLL;
  localparam int PROD_W   = 2 * XLEN_W;
  localparam int DATA_N   = (MUL_STEP > 1) ? MUL_STEP - 1 : 1;

  // Operands still needed by later stages.
  typedef struct packed {
    logic [XLEN_W:0] mcand;
    logic [XLEN_W:0] mplier;
  } mul_data_t;

  // Accumulated product with its op and tag.
  typedef struct packed {
    muldiv_pkg::muldiv_op_t         op;
    logic [muldiv_pkg::TAG_W-1:0]   tag;
    logic [PROD_W-1:0]              prod;
  } mul_acc_t;

  logic      r_valid [MUL_STEP];
  mul_acc_t  r_acc   [MUL_STEP];
  mul_data_t r_data  [DATA_N];

  mul_acc_t  w_last;
  logic      w_high;

  for (genvar s = 0; s < MUL_STEP; s++) begin : g_stage
    logic                       w_valid;
    mul_data_t                  w_data;
    mul_acc_t                   w_acc;
    logic signed [MUL_UNROLL:0] w_chunk;
    logic signed [PROD_W-1:0]   w_term;
    logic [PROD_W-1:0]          w_prod;

    if (s == 0) begin : g_first
      assign w_valid = i_valid;
      assign w_data  = '{mcand: i_disp.rs1, mplier: i_disp.rs2};
      assign w_acc   = '{op: i_disp.op, tag: i_disp.tag, prod: '0};
    end else begin : g_next
      assign w_valid = r_valid[s-1];
      assign w_data  = r_data[s-1];
      assign w_acc   = r_acc[s-1];
    end

    // The top chunk holds the multiplier sign and is weighted negative.
    if (s == MUL_STEP - 1) begin : g_chunk_top
      assign w_chunk = w_data.mplier[MUL_UNROLL:0];
    end else begin : g_chunk_low
      assign w_chunk = {1'b0, w_data.mplier[MUL_UNROLL-1:0]};
    end

    assign w_term = PROD_W'($signed(w_data.mcand)) * PROD_W'(w_chunk);
    assign w_prod = w_acc.prod + (w_term <<< (s * MUL_UNROLL));

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_valid[s] <= 1'b0;
      end else begin
        r_valid[s] <= w_valid;
      end
    end

    always_ff @(posedge i_clk) begin
      r_acc[s] <= '{op: w_acc.op, tag: w_acc.tag, prod: w_prod};
    end

    if (s < MUL_STEP - 1) begin : g_fwd
      logic [XLEN_W:0] w_mplier_next;

      // Arithmetic shift keeps the sign for the top chunk.
      assign w_mplier_next = $signed(w_data.mplier) >>> MUL_UNROLL;

      always_ff @(posedge i_clk) begin
        r_data[s] <= '{mcand: w_data.mcand, mplier: w_mplier_next};
      end
    end
  end

  assign w_last = r_acc[MUL_STEP-1];

  assign w_high = w_last.op inside {muldiv_pkg::OP_MULH, muldiv_pkg::OP_MULHSU,
                                    muldiv_pkg::OP_MULHU};

  assign o_valid    = r_valid[MUL_STEP-1];
  assign o_res.tag  = w_last.tag;
  assign o_res.data = w_high ? w_last.prod[PROD_W-1 -: XLEN_W] : w_last.prod[XLEN_W-1:0];

endmodule

// ==== muldiv/muldiv_div_iter.sv ====
`timescale 1ns/100ps

module muldiv_div_iter (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_valid,
  input  muldiv_pkg::muldiv_disp_t i_disp,
  input  logic                     i_ack,
  output logic                     o_idle,
  output logic                     o_valid,
  output muldiv_pkg::muldiv_res_t  o_res
);

  localparam int XLEN_W = muldiv_pkg::XLEN_W;
  localparam int CNT_W  = $clog2(XLEN_W);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_t;

  div_state_t                   r_state;
  logic [CNT_W-1:0]             r_cnt;
  logic [XLEN_W-1:0]            r_quot;
  logic [XLEN_W-1:0]            r_rem;
  logic [XLEN_W-1:0]            r_divisor;
  logic                         r_neg_q;
  logic                         r_neg_r;
  logic                         r_is_rem;
  logic [muldiv_pkg::TAG_W-1:0] r_tag;

  logic              w_neg1;
  logic              w_neg2;
  logic [XLEN_W-1:0] w_abs1;
  logic [XLEN_W-1:0] w_abs2;
  logic              w_div_zero;
  logic              w_overflow;
  logic              w_special;
  logic [XLEN_W:0]   w_shift;
  logic [XLEN_W:0]   w_diff;
  logic              w_ge;
  logic [XLEN_W-1:0] w_quot_out;
  logic [XLEN_W-1:0] w_rem_out;

  // The extension bit is the sign, and is zero for unsigned ops.
  assign w_neg1 = i_disp.rs1[XLEN_W];
  assign w_neg2 = i_disp.rs2[XLEN_W];
  assign w_abs1 = w_neg1 ? -i_disp.rs1[XLEN_W-1:0] : i_disp.rs1[XLEN_W-1:0];
  assign w_abs2 = w_neg2 ? -i_disp.rs2[XLEN_W-1:0] : i_disp.rs2[XLEN_W-1:0];

  // Only a signed op extends to these patterns.
  assign w_div_zero = (i_disp.rs2 == '0);
  assign w_overflow = (i_disp.rs1 == {2'b11, {(XLEN_W-1){1'b0}}}) && (i_disp.rs2 == '1);
  assign w_special  = w_div_zero || w_overflow;

  // Restoring step on the shifted partial remainder.
  assign w_shift = {r_rem, r_quot[XLEN_W-1]};
  assign w_diff  = w_shift - {1'b0, r_divisor};
  assign w_ge    = !w_diff[XLEN_W];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= DIV_IDLE;
      r_cnt   <= '0;
    end else begin
      case (r_state)
        DIV_IDLE: begin
          if (i_valid) begin
            r_state <= w_special ? DIV_DONE : DIV_RUN;
            r_cnt   <= CNT_W'(XLEN_W - 1);
          end
        end
        DIV_RUN: begin
          if (r_cnt == '0) begin
            r_state <= DIV_DONE;
          end
          r_cnt <= r_cnt - 1'b1;
        end
        DIV_DONE: begin
          if (i_ack) begin
            r_state <= DIV_IDLE;
          end
        end
        default: begin
          r_state <= DIV_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    case (r_state)
      DIV_IDLE: begin
        if (i_valid) begin
          r_tag     <= i_disp.tag;
          r_is_rem  <= (i_disp.op == muldiv_pkg::OP_REM) || (i_disp.op == muldiv_pkg::OP_REMU);
          r_divisor <= w_abs2;
          if (w_div_zero) begin
            r_quot  <= '1;
            r_rem   <= i_disp.rs1[XLEN_W-1:0];
            r_neg_q <= 1'b0;
            r_neg_r <= 1'b0;
          end else if (w_overflow) begin
            r_quot  <= i_disp.rs1[XLEN_W-1:0];
            r_rem   <= '0;
            r_neg_q <= 1'b0;
            r_neg_r <= 1'b0;
          end else begin
            // Dividend shifts out of the quotient register.
            r_quot  <= w_abs1;
            r_rem   <= '0;
            r_neg_q <= w_neg1 ^ w_neg2;
            r_neg_r <= w_neg1;
          end
        end
      end
      DIV_RUN: begin
        r_quot <= {r_quot[XLEN_W-2:0], w_ge};
        r_rem  <= w_ge ? w_diff[XLEN_W-1:0] : w_shift[XLEN_W-1:0];
      end
      default: begin
      end
    endcase
  end

  // Remainder takes the dividend sign.
  assign w_quot_out = r_neg_q ? -r_quot : r_quot;
  assign w_rem_out  = r_neg_r ? -r_rem : r_rem;

  assign o_idle     = (r_state == DIV_IDLE);
  assign o_valid    = (r_state == DIV_DONE);
  assign o_res.tag  = r_tag;
  assign o_res.data = r_is_rem ? w_rem_out : w_quot_out;

endmodule

// ==== source/muldiv_result.sv ====
`timescale 1ns/100ps

module muldiv_result (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_mul_valid,
  input  muldiv_pkg::muldiv_res_t i_mul_res,
  input  logic                    i_div_valid,
  input  muldiv_pkg::muldiv_res_t i_div_res,
  output logic                    o_div_ack,
  output logic                    o_res_valid,
  output muldiv_pkg::muldiv_res_t o_res
);

  // Multiplier cannot stall, so it always wins.
  assign o_div_ack = i_div_valid && !i_mul_valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_res_valid <= 1'b0;
    end else begin
      o_res_valid <= i_mul_valid || i_div_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_mul_valid) begin
      o_res <= i_mul_res;
    end else begin
      o_res <= i_div_res;
    end
  end

endmodule

// ==== source/muldiv_top.sv ====
`timescale 1ns/100ps

module muldiv_top #(
  parameter int MUL_UNROLL = 8
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_req_valid,
  input  muldiv_pkg::muldiv_req_t i_req,
  output logic                    o_req_ready,
  output logic                    o_res_valid,
  output muldiv_pkg::muldiv_res_t o_res
);

  muldiv_pkg::muldiv_disp_t w_disp;
  logic                     w_mul_valid;
  logic                     w_div_valid;
  logic                     w_div_idle;

  logic                     w_mul_out_valid;
  muldiv_pkg::muldiv_res_t  w_mul_res;
  logic                     w_div_out_valid;
  muldiv_pkg::muldiv_res_t  w_div_res;
  logic                     w_div_ack;

  muldiv_decode u_decode (
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .i_div_idle  (w_div_idle),
    .o_req_ready (o_req_ready),
    .o_mul_valid (w_mul_valid),
    .o_div_valid (w_div_valid),
    .o_disp      (w_disp)
  );

  muldiv_mul_pipe #(
    .MUL_UNROLL (MUL_UNROLL)
  ) u_mul_pipe (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (w_mul_valid),
    .i_disp    (w_disp),
    .o_valid   (w_mul_out_valid),
    .o_res     (w_mul_res)
  );

  muldiv_div_iter u_div_iter (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (w_div_valid),
    .i_disp    (w_disp),
    .i_ack     (w_div_ack),
    .o_idle    (w_div_idle),
    .o_valid   (w_div_out_valid),
    .o_res     (w_div_res)
  );

  muldiv_result u_result (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_mul_valid (w_mul_out_valid),
    .i_mul_res   (w_mul_res),
    .i_div_valid (w_div_out_valid),
    .i_div_res   (w_div_res),
    .o_div_ack   (w_div_ack),
    .o_res_valid (o_res_valid),
    .o_res       (o_res)
  );

endmodule

// ==== test/tb_muldiv_top.sv ====
`timescale 1ns/100ps

module tb_muldiv_top;

  localparam int XLEN_W     = muldiv_pkg::XLEN_W;
  localparam int TAG_W      = muldiv_pkg::TAG_W;
  localparam int TAG_N      = 1 << TAG_W;
  // Matches the DUT default.
  localparam int MUL_UNROLL = 8;
  localparam int MUL_STEP   = (XLEN_W + MUL_UNROLL - 1) / MUL_UNROLL;
  localparam int CLK_PERIOD = 4;
  // Operations issued over all six tests.
  localparam int N_OPS        = 455;
  localparam int WATCHDOG_CYC = N_OPS * (XLEN_W + 2) + 1000;

  logic                    i_clk;
  logic                    i_reset_n;
  logic                    i_req_valid;
  muldiv_pkg::muldiv_req_t i_req;
  logic                    o_req_ready;
  logic                    o_res_valid;
  muldiv_pkg::muldiv_res_t o_res;

  // Scoreboard indexed by tag.
  muldiv_pkg::muldiv_res_t exp_res   [TAG_N];
  logic                    pending   [TAG_N];
  logic                    is_mul    [TAG_N];
  int                      issue_cyc [TAG_N];
  int                      n_pending;
  int                      next_tag;
  int                      cycle;

  muldiv_top dut0 (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_req_ready (o_req_ready),
    .o_res_valid (o_res_valid),
    .o_res       (o_res)
  );

  // Cycle count advances just before each falling edge.
  initial begin
    i_clk = 1'b0;
    cycle = 0;
    forever begin
      #(CLK_PERIOD / 2) i_clk = 1'b1;
      #(CLK_PERIOD / 2);
      cycle = cycle + 1;
      i_clk = 1'b0;
    end
  end

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped.");
  endtask

  task automatic report_error(input string msg);
    stop_on_failure($sformatf("[ERROR] %0t: %s", $time, msg));
  endtask

  task automatic check_res(input muldiv_pkg::muldiv_res_t got,
                           input muldiv_pkg::muldiv_res_t exp);
    if (got !== exp) begin
      report_error($sformatf("result tag %0d data %08h, expected tag %0d data %08h",
                             got.tag, got.data, exp.tag, exp.data));
    end
  endtask

  task automatic check_ready(input muldiv_pkg::muldiv_op_t op, input logic got,
                             input logic exp);
    if (got !== exp) begin
      report_error($sformatf("ready %b for %s, expected %b", got, op.name(), exp));
    end
  endtask

  task automatic check_latency(input int tag, input int got, input int exp);
    if (got != exp) begin
      report_error($sformatf("multiply tag %0d took %0d cycles, expected %0d", tag, got, exp));
    end
  endtask

  // ISA results from 64-bit arithmetic.
  function automatic logic [XLEN_W-1:0] ref_result(input logic [2:0] f3,
                                                   input logic [XLEN_W-1:0] a,
                                                   input logic [XLEN_W-1:0] b);
    longint            sa;
    longint            sb;
    longint            ub;
    logic [63:0]       prod;
    logic              ovf;
    logic [XLEN_W-1:0] res;
    sa  = longint'($signed(a));
    sb  = longint'($signed(b));
    ub  = longint'({32'b0, b});
    ovf = (a == 32'h8000_0000) && (b == '1);
    case (f3)
      3'b000, 3'b001: prod = sa * sb;
      3'b010:         prod = sa * ub;
      default:        prod = {32'b0, a} * {32'b0, b};
    endcase
    case (f3)
      3'b000:  res = prod[XLEN_W-1:0];
      3'b100:  res = (b == '0) ? '1 : (ovf ? a : XLEN_W'(sa / sb));
      3'b101:  res = (b == '0) ? '1 : a / b;
      3'b110:  res = (b == '0) ? a : (ovf ? '0 : XLEN_W'(sa % sb));
      3'b111:  res = (b == '0) ? a : a % b;
      default: res = prod[2*XLEN_W-1:XLEN_W];
    endcase
    return res;
  endfunction

  // Holds the request until accepted; optionally checks ready on the first edge.
  task automatic issue(input logic [2:0] f3, input logic [XLEN_W-1:0] a,
                       input logic [XLEN_W-1:0] b, input logic chk_rdy, input logic exp_rdy);
    int   tag;
    int   k;
    logic first;
    logic rdy;
    tag = -1;
    while (tag < 0) begin
      for (k = 0; k < TAG_N; k++) begin
        if (tag < 0 && !pending[(next_tag + k) % TAG_N]) begin
          tag = (next_tag + k) % TAG_N;
        end
      end
      if (tag < 0) begin
        @(negedge i_clk);
      end
    end
    next_tag     = (tag + 1) % TAG_N;
    exp_res[tag] = '{tag: TAG_W'(tag), data: ref_result(f3, a, b)};
    is_mul[tag]  = !f3[2];
    pending[tag] = 1'b1;
    n_pending++;
    i_req_valid = 1'b1;
    i_req       = '{funct3: f3, rs1: a, rs2: b, tag: TAG_W'(tag)};
    first       = 1'b1;
    do begin
      @(posedge i_clk);
      rdy = o_req_ready;
      if (first && chk_rdy) begin
        check_ready(muldiv_pkg::muldiv_op_t'(f3), rdy, exp_rdy);
      end
      first = 1'b0;
    end while (!rdy);
    issue_cyc[tag] = cycle;
    @(negedge i_clk);
    i_req_valid = 1'b0;
  endtask

  task automatic send(input logic [2:0] f3, input logic [XLEN_W-1:0] a,
                      input logic [XLEN_W-1:0] b);
    issue(f3, a, b, 1'b0, 1'b0);
  endtask

  task automatic wait_drain();
    while (n_pending != 0) begin
      @(negedge i_clk);
    end
    repeat (2) @(negedge i_clk);
  endtask

  // Monitor.
  always @(posedge i_clk) begin
    if (i_reset_n && o_res_valid) begin
      if (!pending[o_res.tag]) begin
        report_error($sformatf("result with tag %0d that is not outstanding", o_res.tag));
      end
      check_res(o_res, exp_res[o_res.tag]);
      if (is_mul[o_res.tag]) begin
        check_latency(int'(o_res.tag), cycle - issue_cyc[o_res.tag], MUL_STEP + 1);
      end
      pending[o_res.tag] = 1'b0;
      n_pending--;
    end
  end

  task automatic test_mul_corners();
    logic [XLEN_W-1:0] vals [6];
    int                op;
    int                i;
    int                j;
    vals = '{32'd0, 32'd1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, $urandom()};
    for (op = 0; op < 4; op++) begin
      for (i = 0; i < 6; i++) begin
        for (j = 0; j < 6; j++) begin
          send(3'(op), vals[i], vals[j]);
        end
      end
    end
    for (i = 0; i < 8; i++) begin
      send(3'($urandom_range(3, 0)), $urandom(), $urandom());
    end
    wait_drain();
  endtask

  task automatic test_mul_stream();
    int i;
    for (i = 0; i < 20; i++) begin
      issue(3'($urandom_range(3, 0)), $urandom(), $urandom(), 1'b1, 1'b1);
    end
    wait_drain();
  endtask

  task automatic test_div_rules();
    int op;
    for (op = 4; op < 8; op++) begin
      send(3'(op), $urandom(), $urandom() | 32'd1);
      send(3'(op), 32'd7, 32'd2);
      send(3'(op), 32'hffff_fff9, 32'd2);
      send(3'(op), 32'd7, 32'hffff_fffe);
      send(3'(op), 32'hffff_fff9, 32'hffff_fffe);
      send(3'(op), $urandom(), 32'd0);
      send(3'(op), 32'h8000_0000, 32'hffff_ffff);
      send(3'(op), $urandom(), ($urandom() >> 20) | 32'd1);
    end
    wait_drain();
  endtask

  task automatic test_div_busy();
    send(3'b100, $urandom(), $urandom() | 32'd1);
    // Divider is running, so a multiply still goes but a divide stalls.
    issue(3'b000, $urandom(), $urandom(), 1'b1, 1'b1);
    issue(3'b111, $urandom(), $urandom() | 32'd1, 1'b1, 1'b0);
    wait_drain();
  endtask

  task automatic test_collision();
    int i;
    send(3'b100, $urandom(), $urandom() | 32'd1);
    for (i = 0; i < 40; i++) begin
      send(3'($urandom_range(3, 0)), $urandom(), $urandom());
    end
    wait_drain();
    for (i = 0; i < 3; i++) begin
      send(3'($urandom_range(3, 0)), $urandom(), $urandom());
    end
    send(3'b110, $urandom(), 32'd0);
    for (i = 0; i < 3; i++) begin
      send(3'($urandom_range(3, 0)), $urandom(), $urandom());
    end
    wait_drain();
  endtask

  task automatic test_random_stream();
    int                i;
    logic [XLEN_W-1:0] b;
    for (i = 0; i < 200; i++) begin
      b = $urandom();
      if ($urandom_range(15, 0) == 0) begin
        b = '0;
      end
      send(3'($urandom_range(7, 0)), $urandom(), b);
      repeat ($urandom_range(2, 0)) @(negedge i_clk);
    end
    wait_drain();
  endtask

  initial begin
    int k;
    int left;
    void'($urandom(32'h81ff_4953));
    i_reset_n   = 1'b0;
    i_req_valid = 1'b0;
    i_req       = '0;
    n_pending   = 0;
    next_tag    = 0;
    for (k = 0; k < TAG_N; k++) begin
      pending[k]   = 1'b0;
      is_mul[k]    = 1'b0;
      issue_cyc[k] = 0;
    end
    repeat (4) @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);
    test_mul_corners();
    test_mul_stream();
    test_div_rules();
    test_div_busy();
    test_collision();
    test_random_stream();
    left = 0;
    for (k = 0; k < TAG_N; k++) begin
      left += int'(pending[k]);
    end
    if (left != 0 || n_pending != 0) begin
      stop_on_failure($sformatf("%0d tags still waiting for a result at the end", left));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  // Watchdog.
  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    stop_on_failure($sformatf("Timeout after %0d cycles with %0d results outstanding",
                              WATCHDOG_CYC, n_pending));
  end

endmodule

// ==== muldiv.f ====
common/muldiv_pkg.sv
source/muldiv_decode.sv
muldiv/muldiv_mul_pipe.sv
muldiv/muldiv_div_iter.sv
source/muldiv_result.sv
source/muldiv_top.sv
test/tb_muldiv_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the muldiv testbench with Verilator and runs it.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory."
  exit 1
fi

verilator --binary --timing -j 0 --top-module tb_muldiv_top -f muldiv.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

sim_out=$(./obj_dir/Vtb_muldiv_top 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status."
  exit 1
fi

if grep -qx '>>> PASS' <<< "$sim_out"; then
  echo "Simulation passed."
  exit 0
else
  echo "Simulation did not report a pass."
  exit 1
fi
